//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = memorySystemTb
FILELIST = memorySystem.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

//--- logic/Memory.sv
`timescale 1ns/1ns

module Memory (
	input hackMemPkg::addrT address,
	input logic load,
	input hackMemPkg::wordT ramData, // RAM (0-3839)
	input hackMemPkg::wordT ledWord, // LED (4096)
	input hackMemPkg::wordT butWord, // BUT (4097)
	input hackMemPkg::wordT uartWord, // UART_TX (4098)
	input hackMemPkg::wordT debugWord0, // DEBUG0 (4107)
	input hackMemPkg::wordT debugWord1, // DEBUG1 (4108)
	input hackMemPkg::wordT debugWord2, // DEBUG2 (4109)
	input hackMemPkg::wordT debugWord3, // DEBUG3 (4110)
	input hackMemPkg::wordT debugWord4, // DEBUG4 (4111)
	output hackMemPkg::wordT out,
	output logic loadRam,
	output logic loadLed,
	output logic loadUart,
	output logic loadGo,
	output logic [4:0] loadDebug // One-hot, bit 0 is DEBUG0
);

	logic selRam; // Address decode hits
	logic selLed;
	logic selBut;
	logic selUart;
	logic selGo;
	logic [4:0] selDebug;

	assign selRam = (address <= hackMemPkg::ramTop); // 0x0000 to 0x0EFF
	assign selLed = (address == hackMemPkg::ioLed);
	assign selBut = (address == hackMemPkg::ioBut);
	assign selUart = (address == hackMemPkg::ioUartTx);
	assign selGo = (address == hackMemPkg::ioGo);
	assign selDebug[0] = (address == hackMemPkg::ioDebug0);
	assign selDebug[1] = (address == hackMemPkg::ioDebug1);
	assign selDebug[2] = (address == hackMemPkg::ioDebug2);
	assign selDebug[3] = (address == hackMemPkg::ioDebug3);
	assign selDebug[4] = (address == hackMemPkg::ioDebug4);

	// Decodes are disjoint, so at most one strobe fires
	assign loadRam = load & selRam;
	assign loadLed = load & selLed;
	assign loadUart = load & selUart;
	assign loadGo = load & selGo;
	assign loadDebug = selDebug & {5{load}}; // Buttons get no strobe

	always_comb begin
		if (selRam) begin
			out = ramData;
		end else if (selLed) begin
			out = ledWord;
		end else if (selBut) begin
			out = butWord;
		end else if (selUart) begin
			out = uartWord; // Busy flag for polling
		end else if (selDebug[0]) begin
			out = debugWord0;
		end else if (selDebug[1]) begin
			out = debugWord1;
		end else if (selDebug[2]) begin
			out = debugWord2;
		end else if (selDebug[3]) begin
			out = debugWord3;
		end else if (selDebug[4]) begin
			out = debugWord4;
		end else begin
			out = '0; // GO, gaps and dropped devices
		end
	end

endmodule

//--- logic/hackMemPkg.sv
package hackMemPkg;

	typedef logic [15:0] wordT; // Data word on every path
	typedef logic [15:0] addrT; // CPU address
	typedef logic [11:0] ramAddrT; // RAM word index
	typedef logic [1:0] ledT; // Board LEDs
	typedef logic [1:0] buttonT; // Raw board buttons

	// RAM occupies 0 to ramTop, devices sit at 4096 and up
	localparam addrT ramTop = 16'd3839; // Last RAM address
	localparam int ramWords = 3840; // RAM depth

	localparam addrT ioLed = 16'd4096; // LED register
	localparam addrT ioBut = 16'd4097; // Buttons, read only
	localparam addrT ioUartTx = 16'd4098; // UART transmit and busy
	localparam addrT ioGo = 16'd4103; // GO strobe, write only
	localparam addrT ioDebug0 = 16'd4107; // Debug words
	localparam addrT ioDebug1 = 16'd4108;
	localparam addrT ioDebug2 = 16'd4109;
	localparam addrT ioDebug3 = 16'd4110;
	localparam addrT ioDebug4 = 16'd4111;

	// Short bit period keeps frames cheap to simulate
	localparam int uartClksPerBit = 16; // Clocks per serial bit

	typedef enum logic [1:0] {
		idle, // Line high, waiting for a write
		start, // Start bit, line low
		data, // Eight data bits, LSB first
		stop // Stop bit, line high
	} uartIdleT;

endpackage

//--- logic/ioRegisterBank.sv
`timescale 1ns/1ns

module ioRegisterBank (
	input logic clk,
	input logic rstN,
	input hackMemPkg::wordT inData,
	input logic loadLed,
	input logic loadGo,
	input logic [4:0] loadDebug, // One-hot debug strobes
	input hackMemPkg::buttonT buttonIn, // Asynchronous to clk
	output hackMemPkg::ledT ledOut,
	output logic goPulse,
	output hackMemPkg::wordT ledWord,
	output hackMemPkg::wordT butWord,
	output hackMemPkg::wordT debugWord0,
	output hackMemPkg::wordT debugWord1,
	output hackMemPkg::wordT debugWord2,
	output hackMemPkg::wordT debugWord3,
	output hackMemPkg::wordT debugWord4
);

	hackMemPkg::ledT ledReg; // LED state
	hackMemPkg::buttonT butMeta; // First sync stage
	hackMemPkg::buttonT butSync; // Second sync stage
	logic goReg; // GO strobe delayed one cycle
	hackMemPkg::wordT debugReg [5]; // Debug words 0 to 4

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ledReg <= '0;
		end else if (loadLed) begin
			ledReg <= inData[1:0]; // Upper bits dropped
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			butMeta <= '0;
			butSync <= '0;
		end else begin
			butMeta <= buttonIn;
			butSync <= butMeta; // Stable two edges after input
		end
	end

	// High for exactly the cycle after the GO write
	always_ff @(posedge clk) begin
		if (!rstN) begin
			goReg <= 1'b0;
		end else begin
			goReg <= loadGo;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 5; i++) begin
				debugReg[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 5; i++) begin
				if (loadDebug[i]) begin
					debugReg[i] <= inData;
				end
			end
		end
	end

	assign ledOut = ledReg;
	assign goPulse = goReg;

	assign ledWord = {14'd0, ledReg}; // Zero-extended read-back
	assign butWord = {14'd0, butSync};

	// Same words go to the read mux and the board pins
	assign debugWord0 = debugReg[0];
	assign debugWord1 = debugReg[1];
	assign debugWord2 = debugReg[2];
	assign debugWord3 = debugReg[3];
	assign debugWord4 = debugReg[4];

endmodule

//--- logic/memorySystem.sv
`timescale 1ns/1ns

module memorySystem (
	input logic clk,
	input logic rstN,
	input hackMemPkg::addrT address, // From CPU
	input logic load,
	input hackMemPkg::wordT inData,
	output hackMemPkg::wordT out, // To CPU
	input hackMemPkg::buttonT buttonIn, // Board buttons
	output hackMemPkg::ledT ledOut, // Board LEDs
	output logic txd, // Serial out
	output logic goPulse,
	output hackMemPkg::wordT debug0,
	output hackMemPkg::wordT debug1,
	output hackMemPkg::wordT debug2,
	output hackMemPkg::wordT debug3,
	output hackMemPkg::wordT debug4
);

	logic loadRam; // Decoded write strobes
	logic loadLed;
	logic loadUart;
	logic loadGo;
	logic [4:0] loadDebug;
	hackMemPkg::ramAddrT ramAddr;
	hackMemPkg::wordT ramData; // Read-back words
	hackMemPkg::wordT ledWord;
	hackMemPkg::wordT butWord;
	hackMemPkg::wordT uartWord;

	assign ramAddr = address[11:0]; // RAM needs only the word index

	Memory i_Memory (
		.address(address),
		.load(load),
		.ramData(ramData),
		.ledWord(ledWord),
		.butWord(butWord),
		.uartWord(uartWord),
		.debugWord0(debug0),
		.debugWord1(debug1),
		.debugWord2(debug2),
		.debugWord3(debug3),
		.debugWord4(debug4),
		.out(out),
		.loadRam(loadRam),
		.loadLed(loadLed),
		.loadUart(loadUart),
		.loadGo(loadGo),
		.loadDebug(loadDebug)
	);

	ram3840 i_ram3840 (
		.clk(clk),
		.loadRam(loadRam),
		.ramAddr(ramAddr),
		.inData(inData),
		.ramData(ramData)
	);

	ioRegisterBank i_ioRegisterBank (
		.clk(clk),
		.rstN(rstN),
		.inData(inData),
		.loadLed(loadLed),
		.loadGo(loadGo),
		.loadDebug(loadDebug),
		.buttonIn(buttonIn),
		.ledOut(ledOut),
		.goPulse(goPulse),
		.ledWord(ledWord),
		.butWord(butWord),
		.debugWord0(debug0), // Debug pins double as read-back
		.debugWord1(debug1),
		.debugWord2(debug2),
		.debugWord3(debug3),
		.debugWord4(debug4)
	);

	uartTx i_uartTx (
		.clk(clk),
		.rstN(rstN),
		.loadUart(loadUart),
		.inData(inData),
		.txd(txd),
		.uartWord(uartWord)
	);

endmodule

//--- logic/ram3840.sv
`timescale 1ns/1ns

module ram3840 (
	input logic clk,
	input logic loadRam, // Already qualified by the decoder
	input hackMemPkg::ramAddrT ramAddr,
	input hackMemPkg::wordT inData,
	output hackMemPkg::wordT ramData
);

	hackMemPkg::wordT mem [hackMemPkg::ramWords]; // Word storage

	always_ff @(posedge clk) begin
		if (loadRam) begin
			mem[ramAddr] <= inData; // Visible from next cycle
		end
	end

	// Asynchronous read, out follows address in the same cycle
	// Indices past the top are only reached when the decoder masks RAM
	assign ramData = mem[ramAddr];

endmodule

//--- logic/uartTx.sv
`timescale 1ns/1ns

module uartTx (
	input logic clk,
	input logic rstN,
	input logic loadUart, // Write to 4098
	input hackMemPkg::wordT inData, // Low byte is sent
	output logic txd, // Serial line that idles high
	output hackMemPkg::wordT uartWord // Bit 0 is busy
);

	hackMemPkg::uartIdleT state;
	logic [$clog2(hackMemPkg::uartClksPerBit)-1:0] clkCnt; // Clocks into current bit
	logic [2:0] bitIdx; // Data bit being sent
	logic [7:0] shiftReg; // Bit 0 is on the line
	logic lastClk; // Final clock of a bit period

	assign lastClk = (int'(clkCnt) == hackMemPkg::uartClksPerBit - 1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= hackMemPkg::idle;
			clkCnt <= '0;
			bitIdx <= '0;
		end else begin
			clkCnt <= (state == hackMemPkg::idle || lastClk) ? '0 : clkCnt + 1'b1;
			case (state)
				hackMemPkg::idle: begin
					if (loadUart) begin
						state <= hackMemPkg::start; // Writes while busy never get here
					end
				end
				hackMemPkg::start: begin
					if (lastClk) begin
						state <= hackMemPkg::data;
						bitIdx <= '0;
					end
				end
				hackMemPkg::data: begin
					if (lastClk) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state <= hackMemPkg::stop;
						end
					end
				end
				default: begin
					if (lastClk) begin
						state <= hackMemPkg::idle; // Stop bit done
					end
				end
			endcase
		end
	end

	// Frame payload shifter
	always_ff @(posedge clk) begin
		if (state == hackMemPkg::idle && loadUart) begin
			shiftReg <= inData[7:0];
		end else if (state == hackMemPkg::data && lastClk) begin
			shiftReg <= {1'b0, shiftReg[7:1]}; // Next bit in LSB-first order
		end
	end

	always_comb begin
		case (state)
			hackMemPkg::start: txd = 1'b0;
			hackMemPkg::data: txd = shiftReg[0];
			default: txd = 1'b1; // Idle and stop
		endcase
	end

	assign uartWord = {15'd0, state != hackMemPkg::idle};

endmodule

//--- memorySystem.f
+incdir+test
logic/hackMemPkg.sv
logic/Memory.sv
logic/ram3840.sv
logic/ioRegisterBank.sv
logic/uartTx.sv
logic/memorySystem.sv
test/memorySystemTb.sv

//--- test/memorySystemChecks.svh
`ifndef MEMORY_SYSTEM_CHECKS_SVH
`define MEMORY_SYSTEM_CHECKS_SVH

logic [31:0] lcgState = 32'd52; // LCG state from a fixed seed
hackMemPkg::wordT ramModel [hackMemPkg::ramWords]; // Expected RAM contents

function automatic logic [31:0] nextRandom();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223; // Full-period 32-bit LCG
	return lcgState;
endfunction

function automatic hackMemPkg::wordT randomWord();
	logic [31:0] r;
	r = nextRandom();
	return r[31:16]; // High half has the longer period
endfunction

function automatic hackMemPkg::addrT randomRamAddr();
	hackMemPkg::wordT r;
	r = randomWord();
	return r % 16'd3840; // Anywhere in 0 to 3839
endfunction

task automatic checkWord(
	input string name,
	input hackMemPkg::wordT expected,
	input hackMemPkg::wordT actual
);
	if (actual !== expected) begin
		$display("Error at %0t ns: %s expected 'h%h, got 'h%h", $time, name, expected, actual);
		stopOnFailure();
	end
endtask

task automatic checkLed(
	input string name,
	input hackMemPkg::ledT expected,
	input hackMemPkg::ledT actual
);
	if (actual !== expected) begin
		$display("Error at %0t ns: %s expected 'b%b, got 'b%b", $time, name, expected, actual);
		stopOnFailure();
	end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		stopOnFailure();
	end
endtask

`endif

//--- test/memorySystemTb.sv
`timescale 1ns/1ns

module memorySystemTb;

	logic clk = 1'b0;
	logic rstN;
	hackMemPkg::addrT address; // CPU side
	logic load;
	hackMemPkg::wordT inData;
	hackMemPkg::wordT out;
	hackMemPkg::buttonT buttonIn; // Board side
	hackMemPkg::ledT ledOut;
	logic txd;
	logic goPulse;
	hackMemPkg::wordT debugPins [5]; // debug0 to debug4

	task automatic stopOnFailure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "memorySystemChecks.svh"

	memorySystem i_memorySystem (
		.clk(clk),
		.rstN(rstN),
		.address(address),
		.load(load),
		.inData(inData),
		.out(out),
		.buttonIn(buttonIn),
		.ledOut(ledOut),
		.txd(txd),
		.goPulse(goPulse),
		.debug0(debugPins[0]),
		.debug1(debugPins[1]),
		.debug2(debugPins[2]),
		.debug3(debugPins[3]),
		.debug4(debugPins[4])
	);

	always #4 clk = ~clk; // 8 ns period

	function automatic hackMemPkg::addrT debugAddress(input int k);
		return hackMemPkg::addrT'(hackMemPkg::ioDebug0 + k); // 4107 to 4111
	endfunction

	// Line level in bit period n of an 8N1 frame
	function automatic logic frameBit(input logic [7:0] dataByte, input int n);
		logic [2:0] idx;
		idx = 3'(n - 1);
		if (n == 0) begin
			return 1'b0; // Start bit
		end else if (n == 9) begin
			return 1'b1; // Stop bit
		end
		return dataByte[idx]; // LSB first
	endfunction

	task automatic writeWord(input hackMemPkg::addrT a, input hackMemPkg::wordT d);
		@(posedge clk);
		address <= a;
		load <= 1'b1; // Commits on the next edge
		inData <= d;
	endtask

	task automatic readCheck(
		input hackMemPkg::addrT a,
		input hackMemPkg::wordT expected,
		input string name
	);
		@(posedge clk);
		address <= a;
		load <= 1'b0; // Same edge retires a pending write
		@(negedge clk);
		checkWord(name, expected, out);
	endtask

	task automatic testReset();
		@(negedge clk);
		checkBit("txd", 1'b1, txd);
		checkBit("goPulse", 1'b0, goPulse);
		checkLed("ledOut", 2'b00, ledOut);
		for (int k = 0; k < 5; k++) begin
			checkWord($sformatf("debug%0d", k), '0, debugPins[k]);
		end
		readCheck(hackMemPkg::ioUartTx, 16'd0, "out @4098"); // Not busy
	endtask

	task automatic testRam();
		hackMemPkg::addrT addrList [64];
		hackMemPkg::wordT d;
		for (int i = 0; i < 64; i++) begin
			addrList[i] = (i == 0) ? 16'd8 : randomRamAddr(); // 4104 aliases index 8
			d = randomWord();
			ramModel[addrList[i][11:0]] = d;
			writeWord(addrList[i], d);
		end
		for (int i = 0; i < 64; i++) begin
			readCheck(addrList[i], ramModel[addrList[i][11:0]],
				$sformatf("out @%0d", addrList[i]));
		end
		readCheck(16'd3840, 16'd0, "out @3840"); // Just past RAM
		readCheck(16'd4095, 16'd0, "out @4095");
		readCheck(16'd4104, 16'd0, "out @4104"); // Dropped slot
		writeWord(16'd4104, randomWord());
		readCheck(16'd4104, 16'd0, "out @4104");
		for (int i = 0; i < 64; i++) begin
			readCheck(addrList[i], ramModel[addrList[i][11:0]],
				$sformatf("out @%0d", addrList[i]));
		end
	endtask

	task automatic testLedButtons();
		hackMemPkg::wordT ledData [2];
		hackMemPkg::buttonT pattern [2];
		ledData = '{16'hA5A6, 16'h3C39}; // Low bits 10 then 01
		pattern = '{2'b10, 2'b01};
		for (int i = 0; i < 2; i++) begin
			writeWord(hackMemPkg::ioLed, ledData[i]);
			readCheck(hackMemPkg::ioLed, {14'd0, ledData[i][1:0]}, "out @4096");
			checkLed("ledOut", ledData[i][1:0], ledOut);
		end
		for (int i = 0; i < 2; i++) begin
			@(posedge clk);
			buttonIn <= pattern[i];
			repeat (2) @(posedge clk); // Through both sync flops
			readCheck(hackMemPkg::ioBut, {14'd0, pattern[i]}, "out @4097");
			writeWord(hackMemPkg::ioBut, 16'hFFFF); // Read only
			readCheck(hackMemPkg::ioBut, {14'd0, pattern[i]}, "out @4097");
		end
		checkLed("ledOut", ledData[1][1:0], ledOut);
	endtask

	task automatic testDebugGo();
		hackMemPkg::wordT model [5];
		for (int k = 0; k < 5; k++) begin
			model[k] = '0; // Reset value
		end
		for (int k = 0; k < 5; k++) begin
			model[k] = randomWord();
			writeWord(debugAddress(k), model[k]);
			for (int j = 0; j < 5; j++) begin
				readCheck(debugAddress(j), model[j], $sformatf("out @%0d", debugAddress(j)));
				checkWord($sformatf("debug%0d", j), model[j], debugPins[j]);
			end
		end
		checkBit("goPulse", 1'b0, goPulse);
		writeWord(hackMemPkg::ioGo, 16'h0001);
		@(posedge clk);
		load <= 1'b0; // GO write lands here
		@(negedge clk);
		checkBit("goPulse", 1'b1, goPulse);
		readCheck(hackMemPkg::ioGo, 16'd0, "out @4103"); // Write only
		checkBit("goPulse", 1'b0, goPulse);
	endtask

	// One frame plus two idle bit periods with an optional write while busy
	task automatic sendFrame(
		input hackMemPkg::wordT d,
		input logic poke,
		input hackMemPkg::wordT pokeData
	);
		int bitTime;
		int frameLen;
		int bitNo;
		bitTime = hackMemPkg::uartClksPerBit;
		frameLen = 10 * bitTime;
		readCheck(hackMemPkg::ioUartTx, 16'd0, "out @4098 idle");
		writeWord(hackMemPkg::ioUartTx, d);
		@(posedge clk);
		load <= 1'b0; // Cycle 0 of the frame
		for (int c = 0; c < frameLen + 2 * bitTime; c++) begin
			@(negedge clk);
			bitNo = c / bitTime;
			if (c < frameLen) begin
				checkWord("out @4098 busy", 16'd1, out);
				if (c % bitTime == bitTime / 2) begin // Mid bit
					checkBit($sformatf("txd bit %0d", bitNo), frameBit(d[7:0], bitNo), txd);
				end
			end else begin
				checkWord("out @4098 done", 16'd0, out);
				checkBit("txd after stop", 1'b1, txd);
			end
			@(posedge clk);
			load <= poke && (c == 3 * bitTime + 2); // Lands in data bit 2
			inData <= pokeData;
		end
	endtask

	task automatic testUartFrame();
		sendFrame(randomWord(), 1'b0, 16'd0);
	endtask

	task automatic testUartBusy();
		hackMemPkg::wordT d;
		d = randomWord();
		sendFrame(d, 1'b1, d ^ 16'h00A5); // Different byte that must be dropped
	endtask

	initial begin
		int budgetCycles;
		// Two frames with idle tails dominate the run time
		budgetCycles = 2 * 12 * hackMemPkg::uartClksPerBit + 4 * 64 + 300;
		#(budgetCycles * 8);
		$display("Watchdog expired after %0d cycles, the tests did not finish", budgetCycles);
		stopOnFailure();
	end

	initial begin
		rstN <= 1'b0;
		address <= '0;
		load <= 1'b0;
		inData <= '0;
		buttonIn <= '0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		testReset();
		testRam();
		testLedButtons();
		testDebugGo();
		testUartFrame();
		testUartBusy();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
